// File: verilog/aes_pkg.sv
package aes_pkg;

    localparam int AES_ROUNDS = 14;

    typedef logic [127:0] aes_block_t;
    typedef logic [255:0] aes_key_t;
    typedef logic [15:0]  aes_keep_t;
    typedef logic [3:0]   aes_round_t;

    // one-hot, one bit per state
    typedef enum logic [5:0] {
        ST_KEY_LO  = 6'b000001,
        ST_KEY_HI  = 6'b000010,
        ST_COUNTER = 6'b000100,
        ST_TEXT    = 6'b001000,
        ST_CIPHER  = 6'b010000,
        ST_OUTPUT  = 6'b100000
    } aes_ctr_state_e;

    typedef struct packed {
        aes_block_t data;  // byte 0 sits in bits 127:120
        aes_keep_t  keep;
        logic       last;
    } axis_beat_t;

    typedef struct packed {
        logic key_lo_load;
        logic key_hi_load;
        logic counter_load;
        logic text_load;
        logic cipher_step;
        logic output_done;
    } aes_ctrl_t;

    // forward S-box, row selected by the high nibble, column by the low nibble
    localparam logic [0:15][7:0] SBOX_ROW [16] = '{
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sub_byte(input logic [7:0] b);
        return SBOX_ROW[b[7:4]][b[3:0]];
    endfunction

    // multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // round constant for key word 8*idx, idx runs 1 to 7 for AES-256
    function automatic logic [7:0] rcon(input aes_round_t idx);
        logic [7:0] r;
        r = 8'h01;
        for (int k = 2; k <= 7; k++) begin
            if (k <= int'(idx)) begin
                r = xtime(r);
            end
        end
        return r;
    endfunction

endpackage

// File: verilog/aes_ctr_fsm.sv
module aes_ctr_fsm import aes_pkg::*; (
    input  logic      Clk,
    input  logic      rst_n,
    input  logic      s_tvalid,
    input  logic      m_tready,
    input  logic      s_last,
    input  logic      round_last,
    output logic      s_tready,
    output logic      m_tvalid,
    output logic      round_enable,
    output aes_ctrl_t ctrl
);

    aes_ctr_state_e state;
    aes_ctr_state_e next_state;
    logic           last_reg;  // tlast of the block being encrypted
    logic           s_fire;
    logic           m_fire;

    assign s_tready = (state == ST_KEY_LO) | (state == ST_KEY_HI) |
                      (state == ST_COUNTER) | (state == ST_TEXT);
    assign m_tvalid = (state == ST_OUTPUT);
    assign s_fire   = s_tvalid & s_tready;
    assign m_fire   = m_tvalid & m_tready;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state <= ST_KEY_LO;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_KEY_LO:  if (s_fire) next_state = ST_KEY_HI;
            ST_KEY_HI:  if (s_fire) next_state = ST_COUNTER;
            ST_COUNTER: if (s_fire) next_state = ST_TEXT;
            ST_TEXT:    if (s_fire) next_state = ST_CIPHER;
            ST_CIPHER:  if (round_last) next_state = ST_OUTPUT;
            ST_OUTPUT: begin
                if (m_fire) begin
                    next_state = last_reg ? ST_KEY_LO : ST_TEXT;
                end
            end
            default:    next_state = ST_KEY_LO;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            last_reg <= 1'b0;
        end else if (ctrl.text_load) begin
            last_reg <= s_last;
        end
    end

    assign ctrl.key_lo_load  = (state == ST_KEY_LO) & s_fire;
    assign ctrl.key_hi_load  = (state == ST_KEY_HI) & s_fire;
    assign ctrl.counter_load = (state == ST_COUNTER) & s_fire;
    assign ctrl.text_load    = (state == ST_TEXT) & s_fire;
    assign ctrl.cipher_step  = (state == ST_CIPHER);
    assign ctrl.output_done  = m_fire;

    // the accepting edge already moves the counter to round 1
    assign round_enable = ctrl.text_load | ((state == ST_CIPHER) & ~round_last);

endmodule

// File: verilog/aes_round_counter.sv
module aes_round_counter import aes_pkg::*; (
    input  logic       Clk,
    input  logic       rst_n,
    input  logic       round_enable,
    output aes_round_t round_num,
    output logic       round_last
);

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            round_num <= '0;
        end else if (round_enable) begin
            round_num <= round_num + aes_round_t'(1);
        end else begin
            round_num <= '0;  // idle between blocks
        end
    end

    // the final round leaves out MixColumns
    assign round_last = (round_num == aes_round_t'(AES_ROUNDS));

endmodule

// File: verilog/aes_key_schedule.sv
module aes_key_schedule import aes_pkg::*; (
    input  aes_round_t round_num,
    input  aes_key_t   prev_keys,
    output aes_block_t next_key
);

    logic [31:0] w_last;
    logic [31:0] w_sel;
    logic [31:0] w_sub;
    logic [31:0] w_temp;
    logic [31:0] w_old [4];
    logic [31:0] w_new [4];

    // newest word of the previous round key
    assign w_last = prev_keys[31:0];

    // even rounds start a new 256-bit block of words and rotate first
    assign w_sel = round_num[0] ? w_last : {w_last[23:0], w_last[31:24]};

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            w_sub[8*b +: 8] = sub_byte(w_sel[8*b +: 8]);
        end
    end

    assign w_temp = round_num[0] ? w_sub : w_sub ^ {rcon(round_num >> 1), 24'h000000};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            w_old[i] = prev_keys[255 - 32*i -: 32];  // key from two rounds back
        end
        w_new[0] = w_old[0] ^ w_temp;
        for (int i = 1; i < 4; i++) begin
            w_new[i] = w_old[i] ^ w_new[i-1];
        end
    end

    assign next_key = {w_new[0], w_new[1], w_new[2], w_new[3]};

endmodule

// File: verilog/aes_round.sv
module aes_round import aes_pkg::*; (
    input  logic       last,
    input  aes_block_t round_key,
    input  aes_block_t state_in,
    output aes_block_t state_out
);

    logic [7:0] sb [16];
    logic [7:0] sr [16];
    logic [7:0] mc [16];

    // byte k of the block is row k%4 of column k/4
    always_comb begin
        for (int k = 0; k < 16; k++) begin
            sb[k] = sub_byte(state_in[127 - 8*k -: 8]);
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                sr[4*c + r] = sb[4*((c + r) % 4) + r];  // row r rotates left by r
            end
        end
    end

    always_comb begin
        logic [7:0] a [4];
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                a[r] = sr[4*c + r];
            end
            mc[4*c]     = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
            mc[4*c + 1] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
            mc[4*c + 2] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
            mc[4*c + 3] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        end
    end

    always_comb begin
        for (int k = 0; k < 16; k++) begin
            state_out[127 - 8*k -: 8] = (last ? sr[k] : mc[k]) ^ round_key[127 - 8*k -: 8];
        end
    end

endmodule

// File: verilog/aes_ctr_datapath.sv
module aes_ctr_datapath import aes_pkg::*; (
    input  logic       Clk,
    input  logic       rst_n,
    input  aes_ctrl_t  ctrl,
    input  aes_round_t round_num,
    input  axis_beat_t s_beat,
    output axis_beat_t m_beat
);

    aes_key_t   key_reg;      // key bytes 0-15 in the upper half
    aes_key_t   key_pair;     // round keys r-2 and r-1
    aes_block_t counter_reg;
    aes_block_t text_reg;
    aes_block_t state_reg;
    aes_keep_t  keep_reg;
    logic       last_reg;

    logic       first_round;
    logic       final_round;
    aes_block_t next_key;
    aes_block_t round_key;
    aes_block_t round_in;
    aes_block_t round_out;

    assign first_round = (round_num == aes_round_t'(1));
    assign final_round = (round_num == aes_round_t'(AES_ROUNDS));

    // round 1 also applies the initial AddRoundKey to the counter
    assign round_key = first_round ? key_reg[127:0] : next_key;
    assign round_in  = first_round ? (counter_reg ^ key_reg[255:128]) : state_reg;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            key_reg <= '0;
        end else if (ctrl.key_lo_load) begin
            key_reg[255:128] <= s_beat.data;
        end else if (ctrl.key_hi_load) begin
            key_reg[127:0] <= s_beat.data;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            key_pair <= '0;
        end else if (ctrl.text_load) begin
            key_pair <= key_reg;
        end else if (ctrl.cipher_step && !first_round) begin
            key_pair <= {key_pair[127:0], next_key};
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            counter_reg <= '0;
        end else if (ctrl.counter_load) begin
            counter_reg <= s_beat.data;
        end else if (ctrl.output_done) begin
            counter_reg <= counter_reg + 128'd1;  // big-endian since byte 0 is the msb
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            text_reg <= '0;
            keep_reg <= '0;
            last_reg <= 1'b0;
        end else if (ctrl.text_load) begin
            text_reg <= s_beat.data;
            keep_reg <= s_beat.keep;
            last_reg <= s_beat.last;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state_reg <= '0;
        end else if (ctrl.cipher_step) begin
            state_reg <= round_out;
        end
    end

    aes_key_schedule u_key_schedule (
        .round_num (round_num),
        .prev_keys (key_pair),
        .next_key  (next_key)
    );

    aes_round u_round (
        .last      (final_round),
        .round_key (round_key),
        .state_in  (round_in),
        .state_out (round_out)
    );

    assign m_beat.data = text_reg ^ state_reg;
    assign m_beat.keep = keep_reg;
    assign m_beat.last = last_reg;

endmodule

// File: verilog/aes_ctr_top.sv
module aes_ctr_top import aes_pkg::*; (
    input  logic       Clk,
    input  logic       rst_n,
    input  logic       s_tvalid,
    output logic       s_tready,
    input  axis_beat_t s_beat,
    output logic       m_tvalid,
    input  logic       m_tready,
    output axis_beat_t m_beat
);

    aes_ctrl_t  ctrl;
    aes_round_t round_num;
    logic       round_enable;
    logic       round_last;

    aes_ctr_fsm u_fsm (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .s_tvalid     (s_tvalid),
        .m_tready     (m_tready),
        .s_last       (s_beat.last),
        .round_last   (round_last),
        .s_tready     (s_tready),
        .m_tvalid     (m_tvalid),
        .round_enable (round_enable),
        .ctrl         (ctrl)
    );

    aes_round_counter u_round_counter (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .round_enable (round_enable),
        .round_num    (round_num),
        .round_last   (round_last)
    );

    aes_ctr_datapath u_datapath (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .round_num (round_num),
        .s_beat    (s_beat),
        .m_beat    (m_beat)
    );

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic Clk,
    output logic rst_n
);

    initial Clk = 1'b0;
    always #50 Clk = ~Clk;  // period of 100

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge Clk);
        rst_n <= 1'b1;  // released on the fourth rising edge
    end

endmodule

// File: sim/aes_ref_pkg.sv
package aes_ref_pkg;

    import aes_pkg::*;

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = sub_byte(w[8*b +: 8]);
        end
        return r;
    endfunction

    // full AES-256 block encryption, with the key expanded into 60 words
    function automatic aes_block_t aes256_encrypt(input aes_key_t key, input aes_block_t blk);
        logic [31:0] w [60];
        logic [31:0] tmp;
        logic [7:0]  s [16];
        logic [7:0]  t [16];
        aes_block_t  res;
        for (int i = 0; i < 8; i++) begin
            w[i] = key[255 - 32*i -: 32];
        end
        for (int i = 8; i < 60; i++) begin
            tmp = w[i-1];
            if (i % 8 == 0) begin
                tmp = sub_word({tmp[23:0], tmp[31:24]}) ^ {rcon(aes_round_t'(i / 8)), 24'h0};
            end else if (i % 8 == 4) begin
                tmp = sub_word(tmp);
            end
            w[i] = w[i-8] ^ tmp;
        end
        for (int k = 0; k < 16; k++) begin
            s[k] = blk[127 - 8*k -: 8] ^ w[k/4][31 - 8*(k%4) -: 8];
        end
        for (int rnd = 1; rnd <= AES_ROUNDS; rnd++) begin
            for (int k = 0; k < 16; k++) begin
                t[k] = sub_byte(s[(k + 4*(k%4)) % 16]);  // ShiftRows folded into the read
            end
            for (int c = 0; c < 4; c++) begin
                if (rnd != AES_ROUNDS) begin
                    s[4*c]   = xtime(t[4*c] ^ t[4*c+1]) ^ t[4*c+1] ^ t[4*c+2] ^ t[4*c+3];
                    s[4*c+1] = xtime(t[4*c+1] ^ t[4*c+2]) ^ t[4*c] ^ t[4*c+2] ^ t[4*c+3];
                    s[4*c+2] = xtime(t[4*c+2] ^ t[4*c+3]) ^ t[4*c] ^ t[4*c+1] ^ t[4*c+3];
                    s[4*c+3] = xtime(t[4*c+3] ^ t[4*c]) ^ t[4*c] ^ t[4*c+1] ^ t[4*c+2];
                end else begin
                    for (int r = 0; r < 4; r++) begin
                        s[4*c+r] = t[4*c+r];
                    end
                end
            end
            for (int k = 0; k < 16; k++) begin
                s[k] = s[k] ^ w[4*rnd + k/4][31 - 8*(k%4) -: 8];
            end
        end
        for (int k = 0; k < 16; k++) begin
            res[127 - 8*k -: 8] = s[k];
        end
        return res;
    endfunction

endpackage

// File: sim/aes_ctr_tb.sv
module aes_ctr_tb import aes_pkg::*, aes_ref_pkg::*;;

    logic       Clk;
    logic       rst_n;
    logic       s_tvalid;
    logic       s_tready;
    logic       m_tvalid;
    logic       m_tready;
    axis_beat_t s_beat;
    axis_beat_t m_beat;

    integer     seed = 32'hcbc2_8c22;
    int         errors = 0;
    int         tests = 0;
    int         out_count = 0;  // transfers seen on the output port
    int         rx_count = 0;   // outputs taken by the receive task
    axis_beat_t out_q [$];      // transferred beats not yet taken
    logic       in_flight = 1'b0;
    logic       text_seen = 1'b0;
    logic       aborted = 1'b0;

    tb_clock_gen u_clock (.Clk(Clk), .rst_n(rst_n));

    aes_ctr_top dut (
        .Clk(Clk), .rst_n(rst_n),
        .s_tvalid(s_tvalid), .s_tready(s_tready), .s_beat(s_beat),
        .m_tvalid(m_tvalid), .m_tready(m_tready), .m_beat(m_beat)
    );

    always @(posedge Clk) begin
        if (rst_n && m_tvalid && m_tready) begin
            out_q.push_back(m_beat);
            out_count++;
        end
    end

    assert property (@(posedge Clk) disable iff (!rst_n)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_beat)))
    else begin
        $display("output beat changed before its transfer at time %0t", $time);
        errors++;
    end

    assert property (@(posedge Clk) disable iff (!rst_n) !(s_tready && (m_tvalid || in_flight)))
    else begin
        $display("s_tready high while a block is busy at time %0t", $time);
        errors++;
    end

    assert property (@(posedge Clk) disable iff (!rst_n) !text_seen |-> !m_tvalid)
    else begin
        $display("m_tvalid high before any text beat at time %0t", $time);
        errors++;
    end

    task automatic timed_out(input string what);
        $display("timeout: %s gave no response within 100 cycles at time %0t", what, $time);
        errors++;
        aborted = 1'b1;
    endtask

    // m_tready gets a new random value every cycle
    task automatic next_cycle();
        integer r;
        @(posedge Clk);
        #10;
        r = $random(seed);
        m_tready = r[0];
    endtask

    task automatic send_beat(input aes_block_t data, input aes_keep_t keep, input logic last,
                             input logic is_text);
        int n;
        n = 0;
        if (aborted) return;
        s_beat = '{data: data, keep: keep, last: last};
        s_tvalid = 1'b1;
        while (!s_tready && n < 100) begin
            next_cycle();
            n++;
        end
        if (n >= 100) begin
            timed_out("s_tready");
            return;
        end
        next_cycle();  // accepting edge
        s_tvalid = 1'b0;
        if (is_text) begin
            in_flight = 1'b1;
            text_seen = 1'b1;
        end
    endtask

    task automatic receive_beat(output axis_beat_t beat);
        int n;
        n = 0;
        beat = '0;
        if (aborted) return;
        while (out_q.size() == 0 && n < 100) begin
            next_cycle();
            n++;
        end
        if (out_q.size() == 0) begin
            timed_out("m_tvalid");
            return;
        end
        beat = out_q.pop_front();
        rx_count++;
        in_flight = 1'b0;
    endtask

    task automatic check_beat(input axis_beat_t got, input aes_block_t data,
                              input aes_keep_t keep, input logic last);
        assert (got.data == data) else begin
            $display("Mismatch at %0t: m_beat.data got %h expected %h", $time, got.data, data);
            errors++;
        end
        assert (got.keep == keep && got.last == last) else begin
            $display("Mismatch at %0t: m_beat.keep/last got %h/%b expected %h/%b",
                     $time, got.keep, got.last, keep, last);
            errors++;
        end
    endtask

    task automatic rand_block(output aes_block_t b);
        b = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic run_message(input aes_key_t key, input aes_block_t ctr, input int beats);
        aes_block_t text;
        axis_beat_t got;
        aes_keep_t  keep;
        send_beat(key[255:128], '1, 1'b0, 1'b0);
        send_beat(key[127:0], '1, 1'b0, 1'b0);
        send_beat(ctr, '1, 1'b0, 1'b0);
        for (int i = 0; i < beats; i++) begin
            rand_block(text);
            keep = aes_keep_t'($random(seed));
            send_beat(text, keep, i == beats - 1, 1'b1);
            receive_beat(got);
            if (!aborted) check_beat(got, text ^ aes256_encrypt(key, ctr + 128'(i)), keep,
                                     i == beats - 1);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        aes_key_t   key;
        aes_block_t ctr;
        axis_beat_t got;
        int         n;
        int         mark;
        s_tvalid = 1'b0;
        s_beat = '0;
        m_tready = 1'b0;
        n = 0;
        #10;
        while (!rst_n && n < 100) begin
            next_cycle();
            n++;
        end
        if (n >= 100) timed_out("rst_n");

        mark = errors;
        repeat (3) next_cycle();
        assert (s_tready && !m_tvalid) else begin
            $display("Mismatch at %0t: s_tready/m_tvalid got %b/%b expected 1/0",
                     $time, s_tready, m_tvalid);
            errors++;
        end
        report_test("reset state", mark);

        // FIPS-197 AES-256 vector, with zero text the output is the cipher block itself
        mark = errors;
        for (int i = 0; i < 32; i++) key[255 - 8*i -: 8] = 8'(i);
        send_beat(key[255:128], '1, 1'b0, 1'b0);
        send_beat(key[127:0], '1, 1'b0, 1'b0);
        send_beat(128'h00112233445566778899aabbccddeeff, '1, 1'b0, 1'b0);
        send_beat('0, '1, 1'b1, 1'b1);
        n = 0;
        while (!aborted && !m_tvalid && n < 100) begin
            next_cycle();
            n++;
        end
        if (n >= 100) timed_out("m_tvalid");
        assert (aborted || n == AES_ROUNDS) else begin
            $display("Mismatch at %0t: m_tvalid latency got %0d edges expected %0d",
                     $time, n, AES_ROUNDS);
            errors++;
        end
        receive_beat(got);
        if (!aborted) check_beat(got, 128'h8ea2b7ca516745bfeafc49904b496089, '1, 1'b1);
        report_test("known answer", mark);

        mark = errors;
        key = {$random(seed), $random(seed), $random(seed), $random(seed),
               $random(seed), $random(seed), $random(seed), $random(seed)};
        ctr = {$random(seed), $random(seed), 64'hffff_ffff_ffff_ffff};
        run_message(key, ctr, 5);
        report_test("counter carry", mark);

        mark = errors;
        key = {$random(seed), $random(seed), $random(seed), $random(seed),
               $random(seed), $random(seed), $random(seed), $random(seed)};
        rand_block(ctr);
        run_message(key, ctr, 3);
        report_test("keep, last and rekey", mark);

        mark = errors;
        next_cycle();
        assert (out_count == 9 && rx_count == 9 && out_q.size() == 0) else begin
            $display("%0d outputs transferred, %0d received, %0d unread, 9 expected",
                     out_count, rx_count, out_q.size());
            errors++;
        end
        report_test("back-pressure", mark);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/aes_pkg.sv
verilog/aes_ctr_fsm.sv
verilog/aes_round_counter.sv
verilog/aes_key_schedule.sv
verilog/aes_round.sv
verilog/aes_ctr_datapath.sv
verilog/aes_ctr_top.sv
sim/tb_clock_gen.sv
sim/aes_ref_pkg.sv
sim/aes_ctr_tb.sv

// File: Makefile
SOURCES := $(shell cat sources.f)

.PHONY: all run clean

all: obj_dir/Vaes_ctr_tb

obj_dir/Vaes_ctr_tb: sources.f $(SOURCES)
	verilator --binary --timing --assert --top-module aes_ctr_tb -f sources.f

run: obj_dir/Vaes_ctr_tb
	@out="$$(./obj_dir/Vaes_ctr_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
